/* design/apb_sub_pkg.sv */
`default_nettype none

package apb_sub_pkg;

    // Bus widths
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int PROT_W = 3;

    // Command packet fields, low end first
    localparam int CMD_DATA_LSB  = 0;
    localparam int CMD_ADDR_LSB  = CMD_DATA_LSB + DATA_W;
    localparam int CMD_STRB_LSB  = CMD_ADDR_LSB + ADDR_W;
    localparam int CMD_PROT_LSB  = CMD_STRB_LSB + STRB_W;
    localparam int CMD_WRITE_BIT = CMD_PROT_LSB + PROT_W;
    localparam int CMD_W         = CMD_WRITE_BIT + 1;

    // Read data with the error flag above it
    localparam int RSP_ERR_BIT = DATA_W;
    localparam int RSP_W       = DATA_W + 1;

    // Source bit on top, between arbiter and master
    localparam int TAG_CMD_W = CMD_W + 1;
    localparam int TAG_RSP_W = RSP_W + 1;

    localparam int FIFO_DEPTH = 4;

    // Master FSM states
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SETUP  = 2'd1;
    localparam logic [1:0] ST_ACCESS = 2'd2;

    // Register slave map
    localparam int                REG_COUNT     = 16;
    localparam int                REG_IDX_W     = $clog2(REG_COUNT);
    localparam logic [ADDR_W-1:0] REG_SPAN      = ADDR_W'(REG_COUNT * 4);
    localparam logic [ADDR_W-1:0] PROT_BASE     = 12'h020;
    localparam logic [ADDR_W-1:0] WAIT_REG_ADDR = 12'h03C;
    localparam int                WAIT_W        = 2;

endpackage

`default_nettype wire

/* design/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           i_wr_valid,
    output logic                           o_wr_ready,
    input  logic [WIDTH-1:0]               i_wr_data,
    output logic                           o_rd_valid,
    input  logic                           i_rd_ready,
    output logic [WIDTH-1:0]               o_rd_data,
    output logic [$clog2(DEPTH+1)-1:0]     o_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] r_mem [DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;
    logic             w_push;
    logic             w_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_wr_ready = (r_count != CNT_W'(DEPTH));
    assign o_rd_valid = (r_count != '0);
    assign o_rd_data  = r_mem[r_rd_ptr];
    assign o_count    = r_count;

    assign w_push = i_wr_valid && o_wr_ready;
    assign w_pop  = o_rd_valid && i_rd_ready;

    always_ff @(posedge aclk) begin
        if (w_push) begin
            r_mem[r_wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= ptr_inc(r_wr_ptr);
            end
            if (w_pop) begin
                r_rd_ptr <= ptr_inc(r_rd_ptr);
            end
            case ({w_push, w_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    // Empty or full means the pointers meet
    a_ptr_consistent: assert property (@(posedge aclk) disable iff (!aresetn)
        (r_count == '0 || r_count == CNT_W'(DEPTH)) |-> (r_wr_ptr == r_rd_ptr));

endmodule

`default_nettype wire

/* design/apb_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_port_arbiter
    import apb_sub_pkg::*;
(
    input  logic                 aclk,
    input  logic                 aresetn,

    // Source ports
    input  logic                 i_cmd_valid_a,
    output logic                 o_cmd_ready_a,
    input  logic [CMD_W-1:0]     i_cmd_data_a,
    input  logic                 i_cmd_valid_b,
    output logic                 o_cmd_ready_b,
    input  logic [CMD_W-1:0]     i_cmd_data_b,
    output logic                 o_rsp_valid_a,
    input  logic                 i_rsp_ready_a,
    output logic [RSP_W-1:0]     o_rsp_data_a,
    output logic                 o_rsp_valid_b,
    input  logic                 i_rsp_ready_b,
    output logic [RSP_W-1:0]     o_rsp_data_b,

    // Master side, tagged
    output logic                 o_m_cmd_valid,
    input  logic                 i_m_cmd_ready,
    output logic [TAG_CMD_W-1:0] o_m_cmd_data,
    input  logic                 i_m_rsp_valid,
    output logic                 o_m_rsp_ready,
    input  logic [TAG_RSP_W-1:0] i_m_rsp_data
);

    logic r_last_b;
    logic w_grant_a;
    logic w_grant_b;
    logic w_accept;
    logic w_rsp_to_b;

    // On a tie the port not served last wins
    assign w_grant_a = i_cmd_valid_a && (!i_cmd_valid_b || r_last_b);
    assign w_grant_b = i_cmd_valid_b && !w_grant_a;

    assign o_m_cmd_valid = i_cmd_valid_a || i_cmd_valid_b;
    assign o_m_cmd_data  = w_grant_b ? {1'b1, i_cmd_data_b} : {1'b0, i_cmd_data_a};
    assign o_cmd_ready_a = w_grant_a && i_m_cmd_ready;
    assign o_cmd_ready_b = w_grant_b && i_m_cmd_ready;
    assign w_accept      = o_m_cmd_valid && i_m_cmd_ready;

    // Starts as if b went last, so a is favoured
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_last_b <= 1'b1;
        end else if (w_accept) begin
            r_last_b <= w_grant_b;
        end
    end

    // Response goes back by its tag
    assign w_rsp_to_b    = i_m_rsp_data[TAG_RSP_W-1];
    assign o_rsp_valid_a = i_m_rsp_valid && !w_rsp_to_b;
    assign o_rsp_valid_b = i_m_rsp_valid && w_rsp_to_b;
    assign o_rsp_data_a  = i_m_rsp_data[RSP_W-1:0];
    assign o_rsp_data_b  = i_m_rsp_data[RSP_W-1:0];
    assign o_m_rsp_ready = w_rsp_to_b ? i_rsp_ready_b : i_rsp_ready_a;

    // Under contention the grant alternates
    a_alternate: assert property (@(posedge aclk) disable iff (!aresetn)
        (i_cmd_valid_a && i_cmd_valid_b && w_accept) |=>
        (!(i_cmd_valid_a && i_cmd_valid_b) || (w_grant_b == $past(w_grant_a))));

endmodule

`default_nettype wire

/* design/apb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_master
    import apb_sub_pkg::*;
#(
    parameter int CMD_DEPTH = 4,
    parameter int RSP_DEPTH = 4
) (
    input  logic                 aclk,
    input  logic                 aresetn,

    // Tagged command and response streams
    input  logic                 i_cmd_valid,
    output logic                 o_cmd_ready,
    input  logic [TAG_CMD_W-1:0] i_cmd_data,
    output logic                 o_rsp_valid,
    input  logic                 i_rsp_ready,
    output logic [TAG_RSP_W-1:0] o_rsp_data,

    // APB
    output logic                 o_psel,
    output logic                 o_penable,
    output logic [ADDR_W-1:0]    o_paddr,
    output logic                 o_pwrite,
    output logic [DATA_W-1:0]    o_pwdata,
    output logic [STRB_W-1:0]    o_pstrb,
    output logic [PROT_W-1:0]    o_pprot,
    input  logic [DATA_W-1:0]    i_prdata,
    input  logic                 i_pready,
    input  logic                 i_pslverr
);

    localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);
    localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);

    logic                 w_head_valid;
    logic                 w_head_pop;
    logic [TAG_CMD_W-1:0] w_head_raw;
    logic [TAG_CMD_W-1:0] w_head;
    logic [CMD_CNT_W-1:0] w_cmd_count;

    logic                 w_rsp_push;
    logic                 w_rsp_room;
    logic                 w_rsp_pop;
    logic [TAG_RSP_W-1:0] w_rsp_word;
    logic [RSP_CNT_W-1:0] w_rsp_count;

    logic [1:0]           r_state;
    logic [1:0]           w_next_state;
    logic                 w_more_cmds;
    logic                 w_room_after;

    sync_fifo #(
        .WIDTH (TAG_CMD_W),
        .DEPTH (CMD_DEPTH)
    ) u_cmd_fifo (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (i_cmd_valid),
        .o_wr_ready (o_cmd_ready),
        .i_wr_data  (i_cmd_data),
        .o_rd_valid (w_head_valid),
        .i_rd_ready (w_head_pop),
        .o_rd_data  (w_head_raw),
        .o_count    (w_cmd_count)
    );

    // Bus fields come straight from the FIFO head, zero when empty
    assign w_head    = w_head_valid ? w_head_raw : '0;
    assign o_paddr   = w_head[CMD_ADDR_LSB +: ADDR_W];
    assign o_pwrite  = w_head[CMD_WRITE_BIT];
    assign o_pwdata  = o_pwrite ? w_head[CMD_DATA_LSB +: DATA_W] : '0;
    assign o_pstrb   = w_head[CMD_STRB_LSB +: STRB_W];
    assign o_pprot   = w_head[CMD_PROT_LSB +: PROT_W];
    assign o_psel    = (r_state != ST_IDLE);
    assign o_penable = (r_state == ST_ACCESS);

    // Transfer ends: pop the command, push its response
    assign w_head_pop = o_penable && i_pready;
    assign w_rsp_push = w_head_pop;
    assign w_rsp_word = {w_head[TAG_CMD_W-1], i_pslverr, i_prdata};

    sync_fifo #(
        .WIDTH (TAG_RSP_W),
        .DEPTH (RSP_DEPTH)
    ) u_rsp_fifo (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (w_rsp_push),
        .o_wr_ready (w_rsp_room),
        .i_wr_data  (w_rsp_word),
        .o_rd_valid (o_rsp_valid),
        .i_rd_ready (i_rsp_ready),
        .o_rd_data  (o_rsp_data),
        .o_count    (w_rsp_count)
    );

    assign w_rsp_pop = o_rsp_valid && i_rsp_ready;

    // Back-to-back needs a second command and room after this push
    assign w_more_cmds  = (w_cmd_count > CMD_CNT_W'(1));
    assign w_room_after = (int'(w_rsp_count) < RSP_DEPTH - 1) || w_rsp_pop;

    always_comb begin
        w_next_state = r_state;
        case (r_state)
            ST_IDLE: begin
                if (w_head_valid && w_rsp_room) begin
                    w_next_state = ST_SETUP;
                end
            end
            ST_SETUP: begin
                w_next_state = ST_ACCESS;
            end
            ST_ACCESS: begin
                if (i_pready) begin
                    w_next_state = (w_more_cmds && w_room_after) ? ST_SETUP : ST_IDLE;
                end
            end
            default: begin
                w_next_state = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= ST_IDLE;
        end else begin
            r_state <= w_next_state;
        end
    end

    a_enable_sel: assert property (@(posedge aclk) disable iff (!aresetn)
        o_penable |-> o_psel);

    // Request held from SETUP until the slave is ready
    a_req_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (o_psel && !i_pready) |=>
        (o_psel && $stable({o_paddr, o_pwrite, o_pwdata, o_pstrb, o_pprot})));

    // A finished transfer always finds room for its response
    a_rsp_room: assert property (@(posedge aclk) disable iff (!aresetn)
        w_rsp_push |-> w_rsp_room);

endmodule

`default_nettype wire

/* design/apb_reg_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_reg_slave
    import apb_sub_pkg::*;
(
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              i_psel,
    input  logic              i_penable,
    input  logic [ADDR_W-1:0] i_paddr,
    input  logic              i_pwrite,
    input  logic [DATA_W-1:0] i_pwdata,
    input  logic [STRB_W-1:0] i_pstrb,
    input  logic [PROT_W-1:0] i_pprot,
    output logic [DATA_W-1:0] o_prdata,
    output logic              o_pready,
    output logic              o_pslverr
);

    logic [DATA_W-1:0]    r_regs [REG_COUNT];
    logic [WAIT_W-1:0]    r_wait_cnt;
    logic [WAIT_W-1:0]    w_wait_cfg;
    logic [REG_IDX_W-1:0] w_idx;
    logic                 w_access;
    logic                 w_addr_err;
    logic                 w_prot_err;
    logic                 w_err;
    logic                 w_wr_en;

    assign w_access   = i_psel && i_penable;
    assign w_idx      = i_paddr[2 +: REG_IDX_W];
    assign w_wait_cfg = r_regs[WAIT_REG_ADDR[2 +: REG_IDX_W]][WAIT_W-1:0];

    // Outside the bank or not word aligned
    assign w_addr_err = (i_paddr >= REG_SPAN) || (i_paddr[1:0] != 2'b00);
    // Upper half needs a privileged write
    assign w_prot_err = i_pwrite && (i_paddr >= PROT_BASE) && !i_pprot[0];
    assign w_err      = w_addr_err || w_prot_err;

    assign o_pready  = w_access && (r_wait_cnt == w_wait_cfg);
    assign o_pslverr = o_pready && w_err;
    assign o_prdata  = (o_pready && !i_pwrite && !w_err) ? r_regs[w_idx] : '0;
    assign w_wr_en   = o_pready && i_pwrite && !w_err;

    // Wait cycles counted within ACCESS
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wait_cnt <= '0;
        end else if (w_access && !o_pready) begin
            r_wait_cnt <= r_wait_cnt + 1'b1;
        end else begin
            r_wait_cnt <= '0;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                r_regs[i] <= '0;
            end
        end else if (w_wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (i_pstrb[b]) begin
                    r_regs[w_idx][8*b +: 8] <= i_pwdata[8*b +: 8];
                end
            end
        end
    end

    // Master holds ACCESS, so ready comes within three waits
    a_bounded_wait: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(w_access) |-> ##[0:3] o_pready);

endmodule

`default_nettype wire

/* design/apb_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_subsystem_top
    import apb_sub_pkg::*;
(
    input  logic             aclk,
    input  logic             aresetn,

    input  logic             i_cmd_valid_a,
    output logic             o_cmd_ready_a,
    input  logic [CMD_W-1:0] i_cmd_data_a,
    output logic             o_rsp_valid_a,
    input  logic             i_rsp_ready_a,
    output logic [RSP_W-1:0] o_rsp_data_a,

    input  logic             i_cmd_valid_b,
    output logic             o_cmd_ready_b,
    input  logic [CMD_W-1:0] i_cmd_data_b,
    output logic             o_rsp_valid_b,
    input  logic             i_rsp_ready_b,
    output logic [RSP_W-1:0] o_rsp_data_b
);

    logic                 m_cmd_valid;
    logic                 m_cmd_ready;
    logic [TAG_CMD_W-1:0] m_cmd_data;
    logic                 m_rsp_valid;
    logic                 m_rsp_ready;
    logic [TAG_RSP_W-1:0] m_rsp_data;

    // Shared APB bus
    logic                 psel;
    logic                 penable;
    logic [ADDR_W-1:0]    paddr;
    logic                 pwrite;
    logic [DATA_W-1:0]    pwdata;
    logic [STRB_W-1:0]    pstrb;
    logic [PROT_W-1:0]    pprot;
    logic [DATA_W-1:0]    prdata;
    logic                 pready;
    logic                 pslverr;

    apb_port_arbiter u_apb_port_arbiter (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_cmd_valid_a (i_cmd_valid_a),
        .o_cmd_ready_a (o_cmd_ready_a),
        .i_cmd_data_a  (i_cmd_data_a),
        .i_cmd_valid_b (i_cmd_valid_b),
        .o_cmd_ready_b (o_cmd_ready_b),
        .i_cmd_data_b  (i_cmd_data_b),
        .o_rsp_valid_a (o_rsp_valid_a),
        .i_rsp_ready_a (i_rsp_ready_a),
        .o_rsp_data_a  (o_rsp_data_a),
        .o_rsp_valid_b (o_rsp_valid_b),
        .i_rsp_ready_b (i_rsp_ready_b),
        .o_rsp_data_b  (o_rsp_data_b),
        .o_m_cmd_valid (m_cmd_valid),
        .i_m_cmd_ready (m_cmd_ready),
        .o_m_cmd_data  (m_cmd_data),
        .i_m_rsp_valid (m_rsp_valid),
        .o_m_rsp_ready (m_rsp_ready),
        .i_m_rsp_data  (m_rsp_data)
    );

    apb_master #(
        .CMD_DEPTH (FIFO_DEPTH),
        .RSP_DEPTH (FIFO_DEPTH)
    ) u_apb_master (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd_valid (m_cmd_valid),
        .o_cmd_ready (m_cmd_ready),
        .i_cmd_data  (m_cmd_data),
        .o_rsp_valid (m_rsp_valid),
        .i_rsp_ready (m_rsp_ready),
        .o_rsp_data  (m_rsp_data),
        .o_psel      (psel),
        .o_penable   (penable),
        .o_paddr     (paddr),
        .o_pwrite    (pwrite),
        .o_pwdata    (pwdata),
        .o_pstrb     (pstrb),
        .o_pprot     (pprot),
        .i_prdata    (prdata),
        .i_pready    (pready),
        .i_pslverr   (pslverr)
    );

    apb_reg_slave u_apb_reg_slave (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_psel    (psel),
        .i_penable (penable),
        .i_paddr   (paddr),
        .i_pwrite  (pwrite),
        .i_pwdata  (pwdata),
        .i_pstrb   (pstrb),
        .i_pprot   (pprot),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

endmodule

`default_nettype wire

/* test/tb_apb_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apb_subsystem
    import apb_sub_pkg::*;
();

    localparam logic [31:0] SEED        = 32'hdc09_1026;
    localparam int          NUM_CMDS    = 200;
    localparam int          STALL_LIMIT = 2000;
    localparam int          RUN_LIMIT   = 20000;
    localparam int          DRAIN_LIMIT = 2000;

    logic              aclk = 1'b0;
    logic              aresetn;
    logic [1:0]        cmd_valid;
    logic [CMD_W-1:0]  cmd_data [2];
    logic [1:0]        rsp_ready;
    wire  [1:0]        cmd_ready;
    wire  [1:0]        rsp_valid;
    wire  [RSP_W-1:0]  rsp_data [2];

    logic [DATA_W-1:0] model_regs [REG_COUNT];
    logic [RSP_W-1:0]  exp_a [$];
    logic [RSP_W-1:0]  exp_b [$];
    int                errors = 0;
    int                n_accepted = 0;
    int                n_received = 0;
    int                stall_cycles = 0;
    int                done_ports = 0;

    always #10 aclk = ~aclk;

    apb_subsystem_top u_apb_subsystem_top (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_cmd_valid_a (cmd_valid[0]),
        .o_cmd_ready_a (cmd_ready[0]),
        .i_cmd_data_a  (cmd_data[0]),
        .o_rsp_valid_a (rsp_valid[0]),
        .i_rsp_ready_a (rsp_ready[0]),
        .o_rsp_data_a  (rsp_data[0]),
        .i_cmd_valid_b (cmd_valid[1]),
        .o_cmd_ready_b (cmd_ready[1]),
        .i_cmd_data_b  (cmd_data[1]),
        .o_rsp_valid_b (rsp_valid[1]),
        .i_rsp_ready_b (rsp_ready[1]),
        .o_rsp_data_b  (rsp_data[1])
    );

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Mostly legal words, some out of range or misaligned, often the wait register
    function automatic logic [CMD_W-1:0] make_command(input bit random_mode, input int idx);
        logic [CMD_W-1:0]  cmd;
        logic [ADDR_W-1:0] addr;
        int                kind;
        cmd  = '0;
        kind = int'($urandom_range(15, 0));
        if (!random_mode) begin
            addr = ADDR_W'(idx * 4);
        end else if (kind < 2) begin
            addr = ADDR_W'($urandom);
        end else if (kind < 3) begin
            addr = ADDR_W'($urandom_range(REG_COUNT - 1, 0) * 4 + $urandom_range(3, 1));
        end else if (kind < 6) begin
            addr = WAIT_REG_ADDR;
        end else begin
            addr = ADDR_W'($urandom_range(REG_COUNT - 1, 0) * 4);
        end
        cmd[CMD_ADDR_LSB +: ADDR_W] = addr;
        if (random_mode) begin
            cmd[CMD_WRITE_BIT]          = 1'($urandom);
            cmd[CMD_DATA_LSB +: DATA_W] = $urandom;
            cmd[CMD_STRB_LSB +: STRB_W] = STRB_W'($urandom);
            cmd[CMD_PROT_LSB +: PROT_W] = PROT_W'($urandom);
        end
        return cmd;
    endfunction

    // Register bank model, applied in acceptance order
    task automatic apply_model(input logic [CMD_W-1:0] cmd, output logic [RSP_W-1:0] rsp);
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] data;
        logic              wr;
        logic              err;
        int                idx;
        addr = cmd[CMD_ADDR_LSB +: ADDR_W];
        strb = cmd[CMD_STRB_LSB +: STRB_W];
        data = cmd[CMD_DATA_LSB +: DATA_W];
        wr   = cmd[CMD_WRITE_BIT];
        err  = (int'(addr) >= REG_COUNT * 4) || (addr[1:0] != 2'b00)
            || (wr && (addr >= PROT_BASE) && !cmd[CMD_PROT_LSB]);
        idx  = int'(addr) / 4;
        rsp  = '0;
        if (err) begin
            rsp[RSP_ERR_BIT] = 1'b1;
        end else if (wr) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) begin
                    model_regs[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
        end else begin
            rsp[DATA_W-1:0] = model_regs[idx];
        end
    endtask

    task automatic take_command(input int p);
        logic [RSP_W-1:0] rsp;
        apply_model(cmd_data[p], rsp);
        if (p == 0) begin
            exp_a.push_back(rsp);
        end else begin
            exp_b.push_back(rsp);
        end
        n_accepted++;
    endtask

    task automatic take_response(input int p);
        logic [RSP_W-1:0] want;
        logic             found;
        found = 1'b0;
        want  = '0;
        n_received++;
        if (p == 0 && exp_a.size() > 0) begin
            want  = exp_a.pop_front();
            found = 1'b1;
        end else if (p == 1 && exp_b.size() > 0) begin
            want  = exp_b.pop_front();
            found = 1'b1;
        end
        if (!found) begin
            $display("port %0d returned a response with no command outstanding", p);
            errors++;
        end else begin
            check_value((p == 0) ? "response a" : "response b", 64'(want), 64'(rsp_data[p]));
        end
    endtask

    always @(posedge aclk) begin : monitor
        int in_flight;
        in_flight = exp_a.size() + exp_b.size();
        if (aresetn) begin
            if (in_flight > 2 * FIFO_DEPTH) begin
                $display("more commands in flight than the command and response FIFOs hold");
                errors++;
            end
            // Both FIFOs full, so only response back-pressure holds commands off
            if ((|cmd_valid) && !(|cmd_ready) && in_flight == 2 * FIFO_DEPTH) begin
                stall_cycles++;
            end
            for (int p = 0; p < 2; p++) begin
                if (rsp_valid[p] && rsp_ready[p]) begin
                    take_response(p);
                end
            end
            for (int p = 0; p < 2; p++) begin
                if (cmd_valid[p] && cmd_ready[p]) begin
                    take_command(p);
                end
            end
        end
    end

    // Valid holds with stable data until the port accepts it
    task automatic drive_port(input int p, input bit random_mode, input int n);
        int issued;
        int accepted;
        int idle;
        issued   = 0;
        accepted = 0;
        idle     = 0;
        while (accepted < n && idle < STALL_LIMIT) begin
            @(posedge aclk);
            idle++;
            if (cmd_valid[p] && cmd_ready[p]) begin
                accepted++;
                idle = 0;
            end
            if (!cmd_valid[p] || cmd_ready[p]) begin
                if (issued < n && (!random_mode || $urandom_range(3, 0) != 0)) begin
                    cmd_valid[p] <= 1'b1;
                    cmd_data[p]  <= make_command(random_mode, issued);
                    issued++;
                end else begin
                    cmd_valid[p] <= 1'b0;
                end
            end
        end
        if (accepted < n) begin
            $display("port %0d stopped accepting commands after %0d of %0d", p, accepted, n);
            errors++;
            cmd_valid[p] <= 1'b0;
        end
        done_ports++;
    endtask

    task automatic toggle_rsp_ready();
        int cyc;
        cyc = 0;
        while (done_ports < 2 && cyc < RUN_LIMIT) begin
            @(posedge aclk);
            cyc++;
            // A long hold so both FIFOs fill and commands back up
            if (cyc >= 100 && cyc < 160) begin
                rsp_ready <= 2'b00;
            end else begin
                rsp_ready <= {$urandom_range(3, 0) != 0, $urandom_range(3, 0) != 0};
            end
        end
        rsp_ready <= 2'b11;
    endtask

    task automatic wait_drain();
        int cyc;
        cyc = 0;
        while ((exp_a.size() > 0 || exp_b.size() > 0) && cyc < DRAIN_LIMIT) begin
            @(posedge aclk);
            cyc++;
        end
        if (exp_a.size() > 0 || exp_b.size() > 0) begin
            $display("responses still outstanding after %0d cycles of draining", cyc);
            errors++;
        end
    endtask

    initial begin : main
        void'($urandom(SEED));
        aresetn     <= 1'b0;
        cmd_valid   <= 2'b00;
        cmd_data[0] <= '0;
        cmd_data[1] <= '0;
        rsp_ready   <= 2'b00;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        check_value("rsp valid after reset", 64'd0, 64'(rsp_valid));
        rsp_ready <= 2'b11;

        // Both ports read every register straight after reset
        done_ports = 0;
        fork
            drive_port(0, 1'b0, REG_COUNT);
            drive_port(1, 1'b0, REG_COUNT);
        join
        wait_drain();

        done_ports = 0;
        fork
            drive_port(0, 1'b1, NUM_CMDS);
            drive_port(1, 1'b1, NUM_CMDS);
            toggle_rsp_ready();
        join
        wait_drain();

        if (stall_cycles == 0) begin
            $display("command acceptance never stalled under response back-pressure");
            errors++;
        end
        check_value("responses vs commands", 64'(n_accepted), 64'(n_received));
        $display("errors %0d, commands %0d, responses %0d", errors, n_accepted, n_received);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
design/apb_sub_pkg.sv
design/sync_fifo.sv
design/apb_port_arbiter.sv
design/apb_master.sv
design/apb_reg_slave.sv
design/apb_subsystem_top.sv
test/tb_apb_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_apb_subsystem \
    -f compile.f --Mdir obj_dir -o tb_apb_subsystem \
    && ./obj_dir/tb_apb_subsystem | tee /dev/stderr | grep -qx "Finished with no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
